/* bev_top.f */
+incdir+include
src/bev_pkg.sv
src/box_store.sv
src/recipe_check.sv
src/restock_adder.sv
src/order_ctrl.sv
src/bev_top.sv
bench/bev_tb.sv

/* Bender.yml */
package:
  name: bev_top

sources:
  - files:
      - src/bev_pkg.sv
      - src/box_store.sv
      - src/recipe_check.sv
      - src/restock_adder.sv
      - src/order_ctrl.sv
      - src/bev_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - bench/bev_tb.sv

/* include/bev_tb_model.svh */
`ifndef BEV_TB_MODEL_SVH
`define BEV_TB_MODEL_SVH

// expected content of every box
bev_pkg::amount_t m_black [256];
bev_pkg::amount_t m_green [256];
bev_pkg::amount_t m_milk  [256];
bev_pkg::amount_t m_pine  [256];
bev_pkg::month_t  m_month [256];
bev_pkg::day_t    m_day   [256];

// lfsr state
logic [31:0] lfsr_q = 32'h461d_a696;

// fibonacci lfsr, taps 32 22 2 1, one step per bit taken
function automatic logic [31:0] lfsr_bits(input int unsigned n);
    logic [31:0] val;
    val = '0;
    for (int unsigned i = 0; i < n; i++) begin
        lfsr_q = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
        val = {val[30:0], lfsr_q[0]};
    end
    return val;
endfunction

// empty boxes, expiry 0/0
function automatic void model_clear();
    for (int i = 0; i < 256; i++) begin
        m_black[i] = '0;
        m_green[i] = '0;
        m_milk[i]  = '0;
        m_pine[i]  = '0;
        m_month[i] = '0;
        m_day[i]   = '0;
    end
endfunction

// recipe table, one nibble of quarters per ingredient
// black, green, milk, pineapple from the top nibble down
function automatic int model_share(input bev_pkg::drink_type_t kind, input int ing);
    logic [15:0] row;
    case (kind)
        bev_pkg::black_tea:                row = 16'h4000;
        bev_pkg::milk_tea:                 row = 16'h3010;
        bev_pkg::extra_milk_tea:           row = 16'h2020;
        bev_pkg::green_tea:                row = 16'h0400;
        bev_pkg::green_milk_tea:           row = 16'h0220;
        bev_pkg::pineapple_juice:          row = 16'h0004;
        bev_pkg::super_pineapple_tea:      row = 16'h2002;
        bev_pkg::super_pineapple_milk_tea: row = 16'h2011;
    endcase
    return int'(row[15 - 4 * ing -: 4]);
endfunction

// recipe need, quarters of 960, 720 or 480
function automatic bev_pkg::amount_t model_need(input bev_pkg::drink_type_t kind,
                                                input bev_pkg::drink_size_t size,
                                                input int ing);
    bev_pkg::amount_t quarter;
    quarter = (size == bev_pkg::size_l) ? 12'd240 :
              (size == bev_pkg::size_m) ? 12'd180 : 12'd120;
    return bev_pkg::amount_t'(quarter * model_share(kind, ing));
endfunction

// make order, box updated on success only
function automatic bev_pkg::err_code_t model_make(input bev_pkg::box_no_t box,
                                                  input bev_pkg::drink_type_t kind,
                                                  input bev_pkg::drink_size_t size,
                                                  input bev_pkg::month_t month,
                                                  input bev_pkg::day_t day);
    bev_pkg::amount_t nb;
    bev_pkg::amount_t ng;
    bev_pkg::amount_t nm;
    bev_pkg::amount_t np;
    nb = model_need(kind, size, 0);
    ng = model_need(kind, size, 1);
    nm = model_need(kind, size, 2);
    np = model_need(kind, size, 3);
    if (month > m_month[box] || (month == m_month[box] && day > m_day[box]))
        return bev_pkg::no_exp;
    if (m_black[box] < nb || m_green[box] < ng || m_milk[box] < nm || m_pine[box] < np)
        return bev_pkg::no_ing;
    m_black[box] = m_black[box] - nb;
    m_green[box] = m_green[box] - ng;
    m_milk[box]  = m_milk[box] - nm;
    m_pine[box]  = m_pine[box] - np;
    return bev_pkg::no_err;
endfunction

// saturating sum, carry bit flags the clamp
function automatic logic [12:0] model_add(input bev_pkg::amount_t a, input bev_pkg::amount_t b);
    logic [12:0] s;
    s = a + b;
    return s[12] ? 13'h1fff : s;
endfunction

// supply order, always written with the new date
function automatic bev_pkg::err_code_t model_supply(input bev_pkg::box_no_t box,
                                                    input bev_pkg::amount_t black,
                                                    input bev_pkg::amount_t green,
                                                    input bev_pkg::amount_t milk,
                                                    input bev_pkg::amount_t pine,
                                                    input bev_pkg::month_t month,
                                                    input bev_pkg::day_t day);
    logic [12:0] sb;
    logic [12:0] sg;
    logic [12:0] sm;
    logic [12:0] sp;
    sb = model_add(m_black[box], black);
    sg = model_add(m_green[box], green);
    sm = model_add(m_milk[box], milk);
    sp = model_add(m_pine[box], pine);
    m_black[box] = sb[11:0];
    m_green[box] = sg[11:0];
    m_milk[box]  = sm[11:0];
    m_pine[box]  = sp[11:0];
    m_month[box] = month;
    m_day[box]   = day;
    return (sb[12] | sg[12] | sm[12] | sp[12]) ? bev_pkg::ing_of : bev_pkg::no_err;
endfunction

`endif

/* bench/bev_tb.sv */
`timescale 1ns/1ns

module bev_tb;
    import bev_pkg::*;

    `include "bev_tb_model.svh"

    localparam int clk_period  = 100;
    localparam int drive_delay = 5;
    localparam int resp_limit  = 64;
    localparam int rand_orders = 48;
    // orders per test, worst case
    localparam int order_budget = 3 + 13 + 5 + 7 + rand_orders;

    logic        clk;
    logic        inf;
    logic        in_valid;
    logic        in_ready;
    action_t     action;
    drink_type_t drink_type;
    drink_size_t drink_size;
    month_t      today_month;
    day_t        today_day;
    box_no_t     box_no;
    amount_t     sup_black;
    amount_t     sup_green;
    amount_t     sup_milk;
    amount_t     sup_pine;
    logic        out_valid;
    logic        out_ready;
    err_code_t   err_code;
    logic        complete;

    // bookkeeping
    err_code_t exp_err;
    string     test_name;
    int        error_count;
    int        test_errors;
    int        test_count;
    int        order_count;

    bev_top #(
        .box_count (256)
    ) u_dut (
        .clk, .inf, .in_valid, .in_ready, .action, .drink_type, .drink_size,
        .today_month, .today_day, .box_no,
        .sup_black, .sup_green, .sup_milk, .sup_pine,
        .out_valid, .out_ready, .err_code, .complete
    );

    always #(clk_period / 2) clk = ~clk;

    //////////////////////////////
    // response checks
    //////////////////////////////

    // three cycles from accept to response, busy all along
    a_latency: assert property (@(posedge clk) disable iff (!inf)
        (in_valid && in_ready) |=> (!out_valid && !in_ready) [*3] ##1 out_valid)
    else begin
        error_count++;
        $display("response did not follow acceptance by 3 cycles in test %s", test_name);
    end

    a_err_code: assert property (@(posedge clk) disable iff (!inf)
        out_valid |-> (err_code == exp_err))
    else begin
        error_count++;
        $display("Error %s: err_code expected %0d actual %0d",
                 test_name, exp_err, $sampled(err_code));
    end

    a_complete: assert property (@(posedge clk) disable iff (!inf)
        out_valid |-> (complete == (exp_err == no_err)))
    else begin
        error_count++;
        $display("Error %s: complete expected %0b actual %0b",
                 test_name, (exp_err == no_err), $sampled(complete));
    end

    // held response under back-pressure
    a_hold: assert property (@(posedge clk) disable iff (!inf)
        (out_valid && !out_ready) |=>
            (out_valid && $stable(err_code) && $stable(complete)))
    else begin
        error_count++;
        $display("response changed before its handshake in test %s", test_name);
    end

    a_busy: assert property (@(posedge clk) disable iff (!inf)
        out_valid |-> !in_ready)
    else begin
        error_count++;
        $display("in_ready went high while a response was pending in test %s", test_name);
    end

    //////////////////////////////
    // order driving
    //////////////////////////////

    // called just after an edge, returns just after the handshake edge
    task automatic run_order(input action_t act, input drink_type_t kind,
                             input drink_size_t size, input month_t month,
                             input day_t day, input box_no_t box,
                             input amount_t sb, input amount_t sg,
                             input amount_t sm, input amount_t sp,
                             input logic back_pressure);
        int   waited;
        logic done;
        while (!in_ready) begin
            @(posedge clk);
            #drive_delay;
        end
        if (act == act_supply)
            exp_err = model_supply(box, sb, sg, sm, sp, month, day);
        else
            exp_err = model_make(box, kind, size, month, day);
        in_valid    = 1'b1;
        action      = act;
        drink_type  = kind;
        drink_size  = size;
        today_month = month;
        today_day   = day;
        box_no      = box;
        sup_black   = sb;
        sup_green   = sg;
        sup_milk    = sm;
        sup_pine    = sp;
        @(posedge clk);
        #drive_delay;
        in_valid = 1'b0;
        // out_ready picked before each edge, handshake seen ahead of it
        waited = 0;
        done   = 1'b0;
        while (!done) begin
            out_ready = back_pressure ? lfsr_bits(1) : 1'b1;
            done      = out_valid && out_ready;
            @(posedge clk);
            #drive_delay;
            waited++;
            if (!done && waited > resp_limit) begin
                error_count++;
                $display("no response within %0d cycles in test %s", resp_limit, test_name);
                done = 1'b1;
            end
        end
        out_ready = 1'b0;
        order_count++;
    endtask

    task automatic make_order(input box_no_t box, input drink_type_t kind,
                              input drink_size_t size, input month_t month, input day_t day);
        run_order(act_make, kind, size, month, day, box, '0, '0, '0, '0, 1'b0);
    endtask

    task automatic supply_order(input box_no_t box, input amount_t sb, input amount_t sg,
                                input amount_t sm, input amount_t sp,
                                input month_t month, input day_t day);
        run_order(act_supply, black_tea, size_l, month, day, box, sb, sg, sm, sp, 1'b0);
    endtask

    task automatic begin_test(input string name);
        test_name   = name;
        test_errors = error_count;
    endtask

    task automatic end_test();
        test_count++;
        $display("test %s finished with %0d errors", test_name, error_count - test_errors);
    endtask

    //////////////////////////////
    // tests
    //////////////////////////////

    task automatic test_reset();
        begin_test("reset_state");
        assert (in_ready === 1'b1) else begin
            error_count++;
            $display("in_ready is not high after reset");
        end
        assert (out_valid === 1'b0) else begin
            error_count++;
            $display("out_valid is not low after reset");
        end
        assert (complete === 1'b0) else begin
            error_count++;
            $display("complete is not low after reset");
        end
        assert (err_code === no_err) else begin
            error_count++;
            $display("Error %s: err_code expected %0d actual %0d", test_name, no_err, err_code);
        end
        // 0/0 is not past the cleared date, so stock decides
        make_order(8'd1, black_tea, size_s, 4'd0, 5'd0);
        make_order(8'd2, milk_tea, size_m, 4'd3, 5'd5);
        make_order(8'd3, green_tea, size_l, 4'd0, 5'd0);
        end_test();
    endtask

    task automatic test_supply_make();
        int tries;
        begin_test("supply_make");
        supply_order(8'd10, 12'd1000, 12'd500, 12'd800, 12'd300, 4'd12, 5'd31);
        tries = 0;
        exp_err = no_err;
        // milk tea large until black runs out
        while (exp_err != no_ing && tries < 10) begin
            make_order(8'd10, milk_tea, size_l, 4'd6, 5'd15);
            tries++;
        end
        // black still short, a write on the refused order would have wrapped it
        make_order(8'd10, black_tea, size_s, 4'd6, 5'd15);
        // green still covers a small cup
        make_order(8'd10, green_tea, size_s, 4'd6, 5'd15);
        end_test();
    endtask

    task automatic test_expiry();
        begin_test("expiry");
        supply_order(8'd20, 12'd2000, 12'd2000, 12'd2000, 12'd2000, 4'd3, 5'd10);
        make_order(8'd20, black_tea, size_m, 4'd3, 5'd11);
        make_order(8'd20, black_tea, size_m, 4'd4, 5'd1);
        make_order(8'd20, black_tea, size_m, 4'd3, 5'd10);
        make_order(8'd20, black_tea, size_m, 4'd2, 5'd28);
        end_test();
    endtask

    task automatic test_overflow();
        begin_test("overflow");
        supply_order(8'd30, 12'd4000, 12'd4000, 12'd4000, 12'd4000, 4'd9, 5'd9);
        supply_order(8'd30, 12'd200, 12'd50, 12'd200, 12'd200, 4'd9, 5'd9);
        // 4095 holds four large cups, not five
        for (int i = 0; i < 5; i++) begin
            make_order(8'd30, black_tea, size_l, 4'd9, 5'd9);
        end
        end_test();
    endtask

    task automatic test_random(input int count);
        action_t     act;
        drink_type_t kind;
        drink_size_t size;
        month_t      month;
        day_t        day;
        box_no_t     box;
        amount_t     sb;
        amount_t     sg;
        amount_t     sm;
        amount_t     sp;
        begin_test("random_stream");
        for (int i = 0; i < count; i++) begin
            act  = action_t'(lfsr_bits(1));
            kind = drink_type_t'(lfsr_bits(3));
            case (lfsr_bits(2))
                0:       size = size_l;
                1:       size = size_m;
                default: size = size_s;
            endcase
            month = month_t'(lfsr_bits(4) % 12 + 1);
            day   = day_t'(lfsr_bits(5) % 28 + 1);
            // few boxes so orders meet each other
            box = box_no_t'(lfsr_bits(2) + 40);
            sb  = amount_t'(lfsr_bits(11));
            sg  = amount_t'(lfsr_bits(11));
            sm  = amount_t'(lfsr_bits(11));
            sp  = amount_t'(lfsr_bits(11));
            run_order(act, kind, size, month, day, box, sb, sg, sm, sp, 1'b1);
        end
        end_test();
    endtask

    //////////////////////////////
    // main sequence
    //////////////////////////////

    initial begin
        clk         = 1'b0;
        inf         = 1'b0;
        in_valid    = 1'b0;
        action      = act_make;
        drink_type  = black_tea;
        drink_size  = size_l;
        today_month = '0;
        today_day   = '0;
        box_no      = '0;
        sup_black   = '0;
        sup_green   = '0;
        sup_milk    = '0;
        sup_pine    = '0;
        out_ready   = 1'b0;
        exp_err     = no_err;
        test_name   = "none";
        error_count = 0;
        test_errors = 0;
        test_count  = 0;
        order_count = 0;
        model_clear();
        repeat (2) @(posedge clk);
        #drive_delay;
        inf = 1'b1;

        test_reset();
        test_supply_make();
        test_expiry();
        test_overflow();
        test_random(rand_orders);

        $display("%0d tests, %0d orders, %0d errors", test_count, order_count, error_count);
        if (error_count == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

    // run limit from the order count
    initial begin
        #((order_budget * 20 + 100) * clk_period);
        $display("watchdog expired before the tests finished");
        $display("Testbench failed");
        $finish;
    end

endmodule

/* src/bev_top.sv */
`timescale 1ns/1ns

module bev_top #(
    parameter int box_count = 256
) (
    input  logic                 clk,
    input  logic                 inf,
    input  logic                 in_valid,
    output logic                 in_ready,
    input  bev_pkg::action_t     action,
    input  bev_pkg::drink_type_t drink_type,
    input  bev_pkg::drink_size_t drink_size,
    input  bev_pkg::month_t      today_month,
    input  bev_pkg::day_t        today_day,
    input  bev_pkg::box_no_t     box_no,
    input  bev_pkg::amount_t     sup_black,
    input  bev_pkg::amount_t     sup_green,
    input  bev_pkg::amount_t     sup_milk,
    input  bev_pkg::amount_t     sup_pine,
    output logic                 out_valid,
    input  logic                 out_ready,
    output bev_pkg::err_code_t   err_code,
    output logic                 complete
);
    import bev_pkg::*;

    // captured order
    drink_type_t captured_type;
    drink_size_t captured_size;
    month_t      captured_month;
    day_t        captured_day;
    amount_t     captured_black, captured_green, captured_milk, captured_pine;

    // box store ports
    logic        rd_en;
    logic        wr_en;
    box_no_t     rd_box;
    box_no_t     wr_box;
    amount_t     rd_black, rd_green, rd_milk, rd_pine;
    month_t      rd_month;
    day_t        rd_day;
    amount_t     wr_black, wr_green, wr_milk, wr_pine;
    month_t      wr_month;
    day_t        wr_day;

    // datapath results
    err_code_t   make_err;
    amount_t     left_black, left_green, left_milk, left_pine;
    amount_t     sum_black, sum_green, sum_milk, sum_pine;
    logic        overflow;

    order_ctrl u_ctrl (
        .clk, .inf, .in_valid, .in_ready, .action, .drink_type, .drink_size,
        .today_month, .today_day, .box_no,
        .sup_black, .sup_green, .sup_milk, .sup_pine,
        .captured_type, .captured_size, .captured_month, .captured_day,
        .captured_black, .captured_green, .captured_milk, .captured_pine,
        .make_err, .left_black, .left_green, .left_milk, .left_pine,
        .sum_black, .sum_green, .sum_milk, .sum_pine, .overflow,
        .rd_month, .rd_day, .rd_en, .rd_box, .wr_en, .wr_box,
        .wr_black, .wr_green, .wr_milk, .wr_pine, .wr_month, .wr_day,
        .out_valid, .out_ready, .err_code, .complete
    );

    box_store #(
        .box_count (box_count)
    ) u_store (
        .clk, .inf, .rd_en, .rd_box, .wr_en, .wr_box,
        .wr_black, .wr_green, .wr_milk, .wr_pine, .wr_month, .wr_day,
        .rd_black, .rd_green, .rd_milk, .rd_pine, .rd_month, .rd_day
    );

    // make path
    recipe_check u_recipe (
        .clk, .inf,
        .drink_type  (captured_type),
        .drink_size  (captured_size),
        .today_month (captured_month),
        .today_day   (captured_day),
        .box_black   (rd_black),
        .box_green   (rd_green),
        .box_milk    (rd_milk),
        .box_pine    (rd_pine),
        .box_month   (rd_month),
        .box_day     (rd_day),
        .make_err, .left_black, .left_green, .left_milk, .left_pine
    );

    // supply path
    restock_adder u_restock (
        .clk, .inf,
        .sup_black (captured_black),
        .sup_green (captured_green),
        .sup_milk  (captured_milk),
        .sup_pine  (captured_pine),
        .box_black (rd_black),
        .box_green (rd_green),
        .box_milk  (rd_milk),
        .box_pine  (rd_pine),
        .sum_black, .sum_green, .sum_milk, .sum_pine, .overflow
    );

endmodule

/* src/order_ctrl.sv */
`timescale 1ns/1ns

module order_ctrl (
    input  logic                 clk,
    input  logic                 inf,
    // request side
    input  logic                 in_valid,
    output logic                 in_ready,
    input  bev_pkg::action_t     action,
    input  bev_pkg::drink_type_t drink_type,
    input  bev_pkg::drink_size_t drink_size,
    input  bev_pkg::month_t      today_month,
    input  bev_pkg::day_t        today_day,
    input  bev_pkg::box_no_t     box_no,
    input  bev_pkg::amount_t     sup_black,
    input  bev_pkg::amount_t     sup_green,
    input  bev_pkg::amount_t     sup_milk,
    input  bev_pkg::amount_t     sup_pine,
    // captured order to the datapath
    output bev_pkg::drink_type_t captured_type,
    output bev_pkg::drink_size_t captured_size,
    output bev_pkg::month_t      captured_month,
    output bev_pkg::day_t        captured_day,
    output bev_pkg::amount_t     captured_black,
    output bev_pkg::amount_t     captured_green,
    output bev_pkg::amount_t     captured_milk,
    output bev_pkg::amount_t     captured_pine,
    // datapath results
    input  bev_pkg::err_code_t   make_err,
    input  bev_pkg::amount_t     left_black,
    input  bev_pkg::amount_t     left_green,
    input  bev_pkg::amount_t     left_milk,
    input  bev_pkg::amount_t     left_pine,
    input  bev_pkg::amount_t     sum_black,
    input  bev_pkg::amount_t     sum_green,
    input  bev_pkg::amount_t     sum_milk,
    input  bev_pkg::amount_t     sum_pine,
    input  logic                 overflow,
    // stored date, kept by a make write-back
    input  bev_pkg::month_t      rd_month,
    input  bev_pkg::day_t        rd_day,
    // box store
    output logic                 rd_en,
    output bev_pkg::box_no_t     rd_box,
    output logic                 wr_en,
    output bev_pkg::box_no_t     wr_box,
    output bev_pkg::amount_t     wr_black,
    output bev_pkg::amount_t     wr_green,
    output bev_pkg::amount_t     wr_milk,
    output bev_pkg::amount_t     wr_pine,
    output bev_pkg::month_t      wr_month,
    output bev_pkg::day_t        wr_day,
    // response side
    output logic                 out_valid,
    input  logic                 out_ready,
    output bev_pkg::err_code_t   err_code,
    output logic                 complete
);
    import bev_pkg::*;

    typedef enum logic [2:0] {
        st_idle,
        st_read,
        st_compute,
        st_write,
        st_respond
    } state_t;

    state_t    state_q;
    state_t    state_d;
    action_t   cap_action;
    box_no_t   cap_box;
    logic      is_supply;
    err_code_t result;

    //////////////////////////////
    // sequencing
    //////////////////////////////

    // fixed walk, only idle and respond wait on a handshake
    always_comb begin
        state_d = state_q;
        case (state_q)
            st_idle:    if (in_valid) state_d = st_read;
            st_read:    state_d = st_compute;
            st_compute: state_d = st_write;
            st_write:   state_d = st_respond;
            st_respond: if (out_ready) state_d = st_idle;
            default:    state_d = st_idle;
        endcase
    end

    always_ff @(posedge clk or negedge inf) begin
        if (!inf) begin
            state_q <= st_idle;
        end else begin
            state_q <= state_d;
        end
    end

    // one order in flight
    assign in_ready  = (state_q == st_idle);
    assign out_valid = (state_q == st_respond);

    //////////////////////////////
    // order capture
    //////////////////////////////

    always_ff @(posedge clk or negedge inf) begin
        if (!inf) begin
            cap_action <= act_make;
        end else if (in_valid && in_ready) begin
            cap_action <= action;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            cap_box        <= box_no;
            captured_type  <= drink_type;
            captured_size  <= drink_size;
            captured_month <= today_month;
            captured_day   <= today_day;
            captured_black <= sup_black;
            captured_green <= sup_green;
            captured_milk  <= sup_milk;
            captured_pine  <= sup_pine;
        end
    end

    //////////////////////////////
    // write-back and response
    //////////////////////////////

    assign is_supply = (cap_action == act_supply);
    assign result    = is_supply ? (overflow ? ing_of : no_err) : make_err;

    // read strobe for one cycle right after capture
    assign rd_en  = (state_q == st_read);
    assign rd_box = cap_box;

    // supply always writes, make only on success
    assign wr_en    = (state_q == st_write) && (is_supply || (make_err == no_err));
    assign wr_box   = cap_box;
    assign wr_black = is_supply ? sum_black : left_black;
    assign wr_green = is_supply ? sum_green : left_green;
    assign wr_milk  = is_supply ? sum_milk : left_milk;
    assign wr_pine  = is_supply ? sum_pine : left_pine;
    // new expiry on supply, old one kept on make
    assign wr_month = is_supply ? captured_month : rd_month;
    assign wr_day   = is_supply ? captured_day : rd_day;

    // latched on the write edge, held through back-pressure
    always_ff @(posedge clk or negedge inf) begin
        if (!inf) begin
            err_code <= no_err;
            complete <= 1'b0;
        end else if (state_q == st_write) begin
            err_code <= result;
            complete <= (result == no_err);
        end
    end

endmodule

/* src/restock_adder.sv */
`timescale 1ns/1ns

module restock_adder (
    input  logic             clk,
    input  logic             inf,
    input  bev_pkg::amount_t sup_black,
    input  bev_pkg::amount_t sup_green,
    input  bev_pkg::amount_t sup_milk,
    input  bev_pkg::amount_t sup_pine,
    input  bev_pkg::amount_t box_black,
    input  bev_pkg::amount_t box_green,
    input  bev_pkg::amount_t box_milk,
    input  bev_pkg::amount_t box_pine,
    output bev_pkg::amount_t sum_black,
    output bev_pkg::amount_t sum_green,
    output bev_pkg::amount_t sum_milk,
    output bev_pkg::amount_t sum_pine,
    output logic             overflow
);
    import bev_pkg::*;

    // carry bit marks a sum past full scale
    logic [12:0] tot_black;
    logic [12:0] tot_green;
    logic [12:0] tot_milk;
    logic [12:0] tot_pine;

    assign tot_black = box_black + sup_black;
    assign tot_green = box_green + sup_green;
    assign tot_milk  = box_milk + sup_milk;
    assign tot_pine  = box_pine + sup_pine;

    // clamp at full scale
    always_ff @(posedge clk) begin
        sum_black <= tot_black[12] ? amount_max : tot_black[11:0];
        sum_green <= tot_green[12] ? amount_max : tot_green[11:0];
        sum_milk  <= tot_milk[12] ? amount_max : tot_milk[11:0];
        sum_pine  <= tot_pine[12] ? amount_max : tot_pine[11:0];
    end

    // any one slot clamped
    always_ff @(posedge clk or negedge inf) begin
        if (!inf) begin
            overflow <= 1'b0;
        end else begin
            overflow <= tot_black[12] | tot_green[12] | tot_milk[12] | tot_pine[12];
        end
    end

endmodule

/* src/recipe_check.sv */
`timescale 1ns/1ns

module recipe_check (
    input  logic                 clk,
    input  logic                 inf,
    input  bev_pkg::drink_type_t drink_type,
    input  bev_pkg::drink_size_t drink_size,
    input  bev_pkg::month_t      today_month,
    input  bev_pkg::day_t        today_day,
    input  bev_pkg::amount_t     box_black,
    input  bev_pkg::amount_t     box_green,
    input  bev_pkg::amount_t     box_milk,
    input  bev_pkg::amount_t     box_pine,
    input  bev_pkg::month_t      box_month,
    input  bev_pkg::day_t        box_day,
    output bev_pkg::err_code_t   make_err,
    output bev_pkg::amount_t     left_black,
    output bev_pkg::amount_t     left_green,
    output bev_pkg::amount_t     left_milk,
    output bev_pkg::amount_t     left_pine
);
    import bev_pkg::*;

    amount_t need_black;
    amount_t need_green;
    amount_t need_milk;
    amount_t need_pine;
    logic    expired;
    logic    lacking;

    // quarter of the cup volume times the share of one ingredient
    function automatic amount_t need_of(input drink_type_t kind, input drink_size_t size,
                                        input int ing);
        amount_t cup;
        case (size)
            size_l:  cup = cup_l;
            size_m:  cup = cup_m;
            size_s:  cup = cup_s;
            default: cup = cup_s;
        endcase
        return amount_t'((cup >> 2) * share_tab[kind][ing]);
    endfunction

    //////////////////////////////
    // stage 1, recipe lookup
    //////////////////////////////

    // order fields are stable from capture on
    always_ff @(posedge clk) begin
        need_black <= need_of(drink_type, drink_size, ing_black);
        need_green <= need_of(drink_type, drink_size, ing_green);
        need_milk  <= need_of(drink_type, drink_size, ing_milk);
        need_pine  <= need_of(drink_type, drink_size, ing_pine);
    end

    //////////////////////////////
    // stage 2, verdict
    //////////////////////////////

    // expiry day itself still usable
    assign expired = (today_month > box_month) ||
                     ((today_month == box_month) && (today_day > box_day));

    assign lacking = (box_black < need_black) || (box_green < need_green) ||
                     (box_milk < need_milk) || (box_pine < need_pine);

    // expiry wins over stock
    always_ff @(posedge clk or negedge inf) begin
        if (!inf) begin
            make_err <= no_err;
        end else begin
            make_err <= expired ? no_exp : (lacking ? no_ing : no_err);
        end
    end

    // only written back when the verdict is no_err, so wrap is harmless
    always_ff @(posedge clk) begin
        left_black <= box_black - need_black;
        left_green <= box_green - need_green;
        left_milk  <= box_milk - need_milk;
        left_pine  <= box_pine - need_pine;
    end

endmodule

/* src/box_store.sv */
`timescale 1ns/1ns

module box_store #(
    parameter int box_count = 256
) (
    input  logic             clk,
    input  logic             inf,
    input  logic             rd_en,
    input  bev_pkg::box_no_t rd_box,
    input  logic             wr_en,
    input  bev_pkg::box_no_t wr_box,
    input  bev_pkg::amount_t wr_black,
    input  bev_pkg::amount_t wr_green,
    input  bev_pkg::amount_t wr_milk,
    input  bev_pkg::amount_t wr_pine,
    input  bev_pkg::month_t  wr_month,
    input  bev_pkg::day_t    wr_day,
    output bev_pkg::amount_t rd_black,
    output bev_pkg::amount_t rd_green,
    output bev_pkg::amount_t rd_milk,
    output bev_pkg::amount_t rd_pine,
    output bev_pkg::month_t  rd_month,
    output bev_pkg::day_t    rd_day
);
    import bev_pkg::*;

    // one slot per field and box
    amount_t black_mem [box_count];
    amount_t green_mem [box_count];
    amount_t milk_mem  [box_count];
    amount_t pine_mem  [box_count];
    month_t  month_mem [box_count];
    day_t    day_mem   [box_count];

    // every box empty with expiry 0/0 after reset
    always_ff @(posedge clk or negedge inf) begin
        if (!inf) begin
            for (int i = 0; i < box_count; i++) begin
                black_mem[i] <= '0;
                green_mem[i] <= '0;
                milk_mem[i]  <= '0;
                pine_mem[i]  <= '0;
                month_mem[i] <= '0;
                day_mem[i]   <= '0;
            end
        end else if (wr_en) begin
            black_mem[wr_box] <= wr_black;
            green_mem[wr_box] <= wr_green;
            milk_mem[wr_box]  <= wr_milk;
            pine_mem[wr_box]  <= wr_pine;
            month_mem[wr_box] <= wr_month;
            day_mem[wr_box]   <= wr_day;
        end
    end

    // registered read, held until the next strobe
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_black <= black_mem[rd_box];
            rd_green <= green_mem[rd_box];
            rd_milk  <= milk_mem[rd_box];
            rd_pine  <= pine_mem[rd_box];
            rd_month <= month_mem[rd_box];
            rd_day   <= day_mem[rd_box];
        end
    end

endmodule

/* src/bev_pkg.sv */
package bev_pkg;

    //////////////////////////////
    // widths that carry a meaning
    //////////////////////////////

    typedef logic [11:0] amount_t;
    typedef logic [3:0]  month_t;
    typedef logic [4:0]  day_t;
    typedef logic [7:0]  box_no_t;
    typedef logic [2:0]  drink_type_t;
    typedef logic [1:0]  drink_size_t;
    typedef logic        action_t;
    typedef logic [1:0]  err_code_t;
    // quarters of one cup
    typedef logic [2:0]  share_t;

    // drink menu codes
    parameter drink_type_t black_tea                = 3'd0;
    parameter drink_type_t milk_tea                 = 3'd1;
    parameter drink_type_t extra_milk_tea           = 3'd2;
    parameter drink_type_t green_tea                = 3'd3;
    parameter drink_type_t green_milk_tea           = 3'd4;
    parameter drink_type_t pineapple_juice          = 3'd5;
    parameter drink_type_t super_pineapple_tea      = 3'd6;
    parameter drink_type_t super_pineapple_milk_tea = 3'd7;

    // cup sizes, code 2 unused
    parameter drink_size_t size_l = 2'd0;
    parameter drink_size_t size_m = 2'd1;
    parameter drink_size_t size_s = 2'd3;

    parameter action_t act_make   = 1'b0;
    parameter action_t act_supply = 1'b1;

    // response codes
    parameter err_code_t no_err = 2'd0;
    parameter err_code_t no_exp = 2'd1;
    parameter err_code_t no_ing = 2'd2;
    parameter err_code_t ing_of = 2'd3;

    // full scale of one ingredient slot
    parameter amount_t amount_max = 12'd4095;

    // total cup volumes
    parameter amount_t cup_l = 12'd960;
    parameter amount_t cup_m = 12'd720;
    parameter amount_t cup_s = 12'd480;

    // column order of the share table
    parameter int ing_black = 0;
    parameter int ing_green = 1;
    parameter int ing_milk  = 2;
    parameter int ing_pine  = 3;

    // row per drink code, quarters of black, green, milk, pineapple
    parameter share_t share_tab [8][4] = '{
        '{3'd4, 3'd0, 3'd0, 3'd0},
        '{3'd3, 3'd0, 3'd1, 3'd0},
        '{3'd2, 3'd0, 3'd2, 3'd0},
        '{3'd0, 3'd4, 3'd0, 3'd0},
        '{3'd0, 3'd2, 3'd2, 3'd0},
        '{3'd0, 3'd0, 3'd0, 3'd4},
        '{3'd2, 3'd0, 3'd0, 3'd2},
        '{3'd2, 3'd0, 3'd1, 3'd1}
    };

endpackage
